// File: flist.f
common/pitaya_pkg.sv
verilog/apb_region_decoder.sv
verilog/housekeeping.sv
analog/adc_frontend.sv
analog/dac_backend.sv
scope/scope_capture.sv
verilog/pitaya_core.sv
sim/pitaya_core_props.sv
sim/tb_pitaya_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run tb_pitaya_core with Verilator from the project root
# exit status is 0 only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_pitaya_core -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_pitaya_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

// File: sim/tb_pitaya_core.sv
////////////////////////////////////////////////////////////
// drives pitaya_core over APB and the raw ADC ports
// all inputs change on the falling edge of adc_clk
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_pitaya_core;

  import pitaya_pkg::*;

  localparam logic [31:0] scope_base  = 32'(region_scope) << region_lsb;
  localparam logic [31:0] unused_base = 32'h0050_0000; // region 5 has no slave
  localparam int apb_timeout  = 8;    // access cycles before giving up
  localparam int done_timeout = 400;  // ctrl polls allowed per capture
  localparam int n_rows       = 6;

  // levels with their DAC codes (also raw ADC words) and read back words
  localparam logic [13:0] lvl_tab  [n_rows] = '{14'h0000, 14'h1FFF, 14'h2000,
                                                 14'h3FFF, 14'h0123, 14'h2ABC};
  localparam logic [13:0] code_tab [n_rows] = '{14'h1FFF, 14'h0000, 14'h3FFF,
                                                 14'h2000, 14'h1EDC, 14'h3543};
  localparam logic [31:0] rb_tab   [n_rows] = '{32'h0000_0000, 32'h0000_1FFF,
                                                 32'hFFFF_E000, 32'hFFFF_FFFF,
                                                 32'h0000_0123, 32'hFFFF_EABC};

  logic        adc_clk, arst_n_i;
  logic [13:0] adc_dat_a_i, adc_dat_b_i, dac_dat_a_o, dac_dat_b_o;
  logic [7:0]  led_o;
  logic [31:0] paddr_i, pwdata_i, prdata_o;
  logic        psel_i, penable_i, pwrite_i, pready_o, pslverr_o;
  int          errors, checks;
  logic [31:0] seed;

  pitaya_core u_dut (.*);

  bind pitaya_core pitaya_core_props u_props (
    .adc_clk       (adc_clk),
    .arst_n_i      (arst_n_i),
    .hk_psel_i     (hk_psel),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .pready_i      (pready_o),
    .pslverr_i     (pslverr_o),
    .scope_armed_i (u_scope.armed),
    .scope_done_i  (u_scope.done),
    .dac_dat_a_i   (dac_dat_a_o),
    .dac_dat_b_i   (dac_dat_b_o)
  );

  always #5 adc_clk = ~adc_clk; // 100 MHz

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // neg-slope offset code to two's complement keeps the msb
  function automatic logic [13:0] to_signed(input logic [13:0] raw);
    return {raw[13], ~raw[12:0]};
  endfunction

  // buffer word holds sign-extended A in 15:0 and B in 31:16
  function automatic logic [31:0] entry_of(input logic [13:0] a, input logic [13:0] b);
    return {{2{b[13]}}, b, {2{a[13]}}, a};
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %0t ns: %s, got %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  // one APB transfer of a setup cycle and access cycles until pready
  task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int waits);
    logic got;
    got   = 1'b0;
    waits = 0;
    rdata = '0;
    err   = 1'b0;
    @(negedge adc_clk);
    paddr_i   = addr;
    pwrite_i  = wr;
    pwdata_i  = wdata;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(negedge adc_clk);
    penable_i = 1'b1;
    while (!got && waits <= apb_timeout)
    begin
      #1; // response has settled by mid cycle
      if (pready_o)
      begin
        got   = 1'b1;
        rdata = prdata_o;
        err   = pslverr_o;
      end
      else
      begin
        waits++;
        @(negedge adc_clk);
      end
    end
    if (!got)
    begin
      $display("timeout: no pready for address %08h", addr);
      $display("Test failed");
      $finish;
    end
    else
    begin
      @(negedge adc_clk); // completing edge passed
      psel_i    = 1'b0;
      penable_i = 1'b0;
    end
  endtask

  task automatic wait_scope_done();
    logic [31:0] rd;
    logic        err;
    int          nw;
    int          polls;
    rd    = '0;
    polls = 0;
    while (!rd[1] && polls < done_timeout)
    begin
      apb_access(1'b0, scope_base | 32'(off_ctrl), '0, rd, err, nw);
      polls++;
    end
    if (!rd[1])
    begin
      $display("timeout: scope capture never reached done");
      $display("Test failed");
      $finish;
    end
    else
      compare("ctrl after done", rd, 32'h2); // armed dropped
  endtask

  initial
  begin : stimulus
    logic [31:0] rd, exp_word;
    logic        err;
    int          nw, j;
    logic [13:0] raw_a, raw_b, code_a, code_b;
    adc_clk     = 1'b0;
    arst_n_i    = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    paddr_i     = '0;
    pwdata_i    = '0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    errors      = 0;
    checks      = 0;
    seed        = 32'hbe5a_c4c5;
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    arst_n_i = 1'b1;

    ////////////////////////////////////////////////////////////
    // reset state, ID, empty region
    ////////////////////////////////////////////////////////////
    compare("led after reset", 32'(led_o), 32'h0);
    compare("dac a after reset", 32'(dac_dat_a_o), 32'h1FFF); // level zero
    compare("dac b after reset", 32'(dac_dat_b_o), 32'h1FFF);
    apb_access(1'b0, 32'(off_id), '0, rd, err, nw);
    compare("id", rd, hk_id_value);
    compare("id wait states", nw, 0);
    apb_access(1'b0, unused_base | 32'(off_id), '0, rd, err, nw); // would alias the id
    compare("unused region data", rd, 32'h0);
    compare("unused region error", 32'(err), 32'h0);
    compare("unused region wait states", nw, 0);

    ////////////////////////////////////////////////////////////
    // LED, DAC level table, undefined offset
    ////////////////////////////////////////////////////////////
    apb_access(1'b1, 32'(off_led), 32'hA5, rd, err, nw);
    compare("led", 32'(led_o), 32'hA5);
    code_a = 14'h1FFF;
    code_b = 14'h1FFF;
    for (int i = 0; i < n_rows; i++)
    begin
      j = n_rows - 1 - i;                // B walks the table backwards
      apb_access(1'b1, 32'(off_dac_a), 32'(lvl_tab[i]), rd, err, nw);
      compare("dac a at write", 32'(dac_dat_a_o), 32'(code_a)); // not yet
      @(negedge adc_clk);
      compare("dac a next cycle", 32'(dac_dat_a_o), 32'(code_tab[i]));
      apb_access(1'b1, 32'(off_dac_b), 32'(lvl_tab[j]), rd, err, nw);
      compare("dac b at write", 32'(dac_dat_b_o), 32'(code_b));
      @(negedge adc_clk);
      compare("dac b next cycle", 32'(dac_dat_b_o), 32'(code_tab[j]));
      apb_access(1'b0, 32'(off_dac_a), '0, rd, err, nw);
      compare("level a read back", rd, rb_tab[i]);
      apb_access(1'b0, 32'(off_dac_b), '0, rd, err, nw);
      compare("level b read back", rd, rb_tab[j]);
      code_a = code_tab[i];
      code_b = code_tab[j];
    end
    apb_access(1'b1, 32'h14, 32'h1, rd, err, nw);
    compare("undefined hk write error", 32'(err), 32'h1);
    apb_access(1'b0, 32'h14, '0, rd, err, nw);
    compare("undefined hk read error", 32'(err), 32'h1);

    ////////////////////////////////////////////////////////////
    // immediate capture of held random ADC words
    ////////////////////////////////////////////////////////////
    for (int round = 0; round < 2; round++)
    begin
      seed  = xorshift(seed);
      raw_a = seed[13:0];
      seed  = xorshift(seed);
      raw_b = seed[13:0];
      @(negedge adc_clk);
      adc_dat_a_i = raw_a;
      adc_dat_b_i = raw_b;
      apb_access(1'b1, scope_base | 32'(off_ctrl), 32'h3, rd, err, nw); // arm immediately
      wait_scope_done();
      exp_word = entry_of(to_signed(raw_a), to_signed(raw_b));
      for (int i = 0; i < scope_depth; i++)
      begin
        apb_access(1'b0, scope_base | 32'(off_buf_base) | 32'(i * 4), '0, rd, err, nw);
        compare($sformatf("held entry %0d", i), rd, exp_word);
        compare("buffer read wait states", nw, 1);
      end
    end

    // table codes as raw ADC words, the levels are the expected samples
    for (int i = 0; i < n_rows; i++)
    begin
      j = n_rows - 1 - i;
      @(negedge adc_clk);
      adc_dat_a_i = code_tab[i];
      adc_dat_b_i = code_tab[j];
      apb_access(1'b1, scope_base | 32'(off_ctrl), 32'h3, rd, err, nw);
      wait_scope_done();
      apb_access(1'b0, scope_base | 32'(off_buf_base) | 32'((scope_depth - 1) * 4), '0,
                 rd, err, nw);
      compare($sformatf("adc table row %0d last entry", i), rd,
              entry_of(lvl_tab[i], lvl_tab[j]));
    end

    ////////////////////////////////////////////////////////////
    // loopback, immediate and triggered
    ////////////////////////////////////////////////////////////
    apb_access(1'b1, 32'(off_dac_a), 32'h0555, rd, err, nw);
    apb_access(1'b1, 32'(off_dac_b), 32'h3AAA, rd, err, nw);      // negative
    apb_access(1'b1, 32'(off_loop), 32'h1, rd, err, nw);
    apb_access(1'b1, scope_base | 32'(off_ctrl), 32'h3, rd, err, nw);
    wait_scope_done();
    for (int i = 0; i < scope_depth; i++)
    begin
      apb_access(1'b0, scope_base | 32'(off_buf_base) | 32'(i * 4), '0, rd, err, nw);
      compare($sformatf("loopback entry %0d", i), rd, entry_of(14'h0555, 14'h3AAA));
    end
    apb_access(1'b1, scope_base | 32'(off_level), 32'h0100, rd, err, nw);
    apb_access(1'b1, 32'(off_dac_a), 32'h3F00, rd, err, nw);      // well below
    apb_access(1'b1, scope_base | 32'(off_ctrl), 32'h1, rd, err, nw); // wait for cross
    apb_access(1'b0, scope_base | 32'(off_ctrl), '0, rd, err, nw);
    compare("armed before trigger", rd, 32'h1);
    apb_access(1'b1, 32'(off_dac_a), 32'h0200, rd, err, nw);      // step across
    wait_scope_done();
    apb_access(1'b0, scope_base | 32'(off_buf_base), '0, rd, err, nw);
    compare("first triggered entry", rd, entry_of(14'h0200, 14'h3AAA));

    // buffer is read only
    apb_access(1'b1, scope_base | 32'(off_buf_base) | 32'h8, 32'h1234, rd, err, nw);
    compare("buffer write error", 32'(err), 32'h1);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: sim/pitaya_core_props.sv
////////////////////////////////////////////////////////////
// bound into pitaya_core with access to the region 0 select
// and to the scope state through the bind connections
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pitaya_core_props (
  input logic                              adc_clk,
  input logic                              arst_n_i,
  input logic                              hk_psel_i,
  input logic                              penable_i,
  input logic                              pwrite_i,
  input logic                              pready_i,
  input logic                              pslverr_i,
  input logic                              scope_armed_i,
  input logic                              scope_done_i,
  input logic [pitaya_pkg::sample_w-1:0]   dac_dat_a_i,
  input logic [pitaya_pkg::sample_w-1:0]   dac_dat_b_i
);

  logic hk_wr_q; // housekeeping write completed at the last edge

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      hk_wr_q <= 1'b0;
    else
      hk_wr_q <= hk_psel_i & penable_i & pwrite_i & pready_i;
  end

  // error only on the completing cycle
  a_err_with_ready: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    pslverr_i |-> pready_i)
    else $error("pslverr high while pready low");

  a_armed_done: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    !(scope_armed_i && scope_done_i))
    else $error("scope armed and done at once");

  // level register followed by one DAC output stage
  a_dac_a_change: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    $changed(dac_dat_a_i) |-> $past(hk_wr_q))
    else $error("dac a changed without a housekeeping write one cycle before");

  a_dac_b_change: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    $changed(dac_dat_b_i) |-> $past(hk_wr_q))
    else $error("dac b changed without a housekeeping write one cycle before");

endmodule

// File: verilog/pitaya_core.sv
////////////////////////////////////////////////////////////
// single clock domain, everything runs on adc_clk
// each DAC channel drives its own 14-bit parallel port
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pitaya_core (
  input  logic                                 adc_clk,
  input  logic                                 arst_n_i,
  // ADC, neg-slope offset code
  input  logic [pitaya_pkg::sample_w-1:0]      adc_dat_a_i,
  input  logic [pitaya_pkg::sample_w-1:0]      adc_dat_b_i,
  // DAC, neg-slope offset code
  output logic [pitaya_pkg::sample_w-1:0]      dac_dat_a_o,
  output logic [pitaya_pkg::sample_w-1:0]      dac_dat_b_o,
  output logic [7:0]                           led_o,
  // APB requester side
  input  logic [pitaya_pkg::apb_addr_w-1:0]    paddr_i,
  input  logic                                 psel_i,
  input  logic                                 penable_i,
  input  logic                                 pwrite_i,
  input  logic [pitaya_pkg::apb_data_w-1:0]    pwdata_i,
  output logic [pitaya_pkg::apb_data_w-1:0]    prdata_o,
  output logic                                 pready_o,
  output logic                                 pslverr_o
);

  import pitaya_pkg::*;

  ////////////////////////////////////////////////////////////
  // wires
  ////////////////////////////////////////////////////////////

  logic                  hk_psel, scope_psel;         // per-slave selects
  logic [apb_data_w-1:0] hk_prdata, scope_prdata;
  logic                  hk_pready, scope_pready;
  logic                  hk_pslverr, scope_pslverr;

  logic                       dig_loop;               // digital loopback
  logic signed [sample_w-1:0] dac_lvl_a, dac_lvl_b;   // static DAC levels
  logic signed [sample_w-1:0] adc_a, adc_b;           // signed samples

  ////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////

  apb_region_decoder u_decoder (
    .paddr_i         (paddr_i),
    .psel_i          (psel_i),
    .hk_psel_o       (hk_psel),
    .scope_psel_o    (scope_psel),
    .hk_prdata_i     (hk_prdata),
    .hk_pready_i     (hk_pready),
    .hk_pslverr_i    (hk_pslverr),
    .scope_prdata_i  (scope_prdata),
    .scope_pready_i  (scope_pready),
    .scope_pslverr_i (scope_pslverr),
    .prdata_o        (prdata_o),
    .pready_o        (pready_o),
    .pslverr_o       (pslverr_o)
  );

  adc_frontend u_adc (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .dig_loop_i  (dig_loop),
    .dac_lvl_a_i (dac_lvl_a),
    .dac_lvl_b_i (dac_lvl_b),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b)
  );

  ////////////////////////////////////////////////////////////
  // processing
  ////////////////////////////////////////////////////////////

  housekeeping u_hk (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .psel_i      (hk_psel),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i[region_lsb-1:0]), // offset within region
    .pwdata_i    (pwdata_i),
    .prdata_o    (hk_prdata),
    .pready_o    (hk_pready),
    .pslverr_o   (hk_pslverr),
    .dig_loop_o  (dig_loop),
    .led_o       (led_o),
    .dac_lvl_a_o (dac_lvl_a),
    .dac_lvl_b_o (dac_lvl_b)
  );

  scope_capture u_scope (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .psel_i    (scope_psel),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i[region_lsb-1:0]),
    .pwdata_i  (pwdata_i),
    .adc_a_i   (adc_a),
    .adc_b_i   (adc_b),
    .prdata_o  (scope_prdata),
    .pready_o  (scope_pready),
    .pslverr_o (scope_pslverr)
  );

  ////////////////////////////////////////////////////////////
  // output side
  ////////////////////////////////////////////////////////////

  dac_backend u_dac (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .dac_lvl_a_i (dac_lvl_a),
    .dac_lvl_b_i (dac_lvl_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

// File: scope/scope_capture.sv
////////////////////////////////////////////////////////////
// 256 sample pairs, immediate or rising level cross on A
// buffer reads take one wait state, buffer writes error out
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module scope_capture (
  input  logic                                   adc_clk,
  input  logic                                   arst_n_i,
  input  logic                                   psel_i,
  input  logic                                   penable_i,
  input  logic                                   pwrite_i,
  input  logic [pitaya_pkg::region_lsb-1:0]      paddr_i,
  input  logic [pitaya_pkg::apb_data_w-1:0]      pwdata_i,
  input  logic signed [pitaya_pkg::sample_w-1:0] adc_a_i,
  input  logic signed [pitaya_pkg::sample_w-1:0] adc_b_i,
  output logic [pitaya_pkg::apb_data_w-1:0]      prdata_o,
  output logic                                   pready_o,
  output logic                                   pslverr_o
);

  import pitaya_pkg::*;

  logic armed, done, started;          // capture state
  logic imm_mode;                      // ctrl bit 1, start without trigger
  logic [scope_ptr_w-1:0] wr_ptr;
  logic signed [sample_w-1:0] trig_lvl;
  logic signed [sample_w-1:0] prev_a;  // A one cycle back
  logic [2*sample_w-1:0] buf_mem [scope_depth]; // {b, a}
  logic [2*sample_w-1:0] rd_data;
  logic rd_wait;                       // second cycle of a buffer read

  logic access, is_ctrl, is_level, is_buf, ctrl_wr, buf_rd, trig_hit, cap_en;
  logic [scope_ptr_w-1:0] rd_idx;

  assign access   = psel_i & penable_i;
  assign is_ctrl  = (paddr_i == off_ctrl);
  assign is_level = (paddr_i == off_level);
  assign is_buf   = (paddr_i >= off_buf_base);
  assign rd_idx   = paddr_i[scope_ptr_w+1:2];       // word index
  assign ctrl_wr  = access & pwrite_i & is_ctrl;
  assign buf_rd   = access & ~pwrite_i & is_buf;

  // rising cross: below before, at or above now
  assign trig_hit = (prev_a < trig_lvl) && (adc_a_i >= trig_lvl);
  assign cap_en   = armed & ~ctrl_wr & (started | imm_mode | trig_hit);

  ////////////////////////////////////////////////////////////
  // control and capture FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      armed    <= 1'b0;
      done     <= 1'b0;
      started  <= 1'b0;
      imm_mode <= 1'b0;
      wr_ptr   <= '0;
      trig_lvl <= '0;
      prev_a   <= '0;
      rd_wait  <= 1'b0;
    end
    else
    begin
      prev_a  <= adc_a_i;
      rd_wait <= buf_rd & ~rd_wait; // drops as the read completes
      if (access && pwrite_i && is_level)
        trig_lvl <= pwdata_i[sample_w-1:0];
      if (ctrl_wr)
      begin
        imm_mode <= pwdata_i[1];
        if (pwdata_i[0])         // arm, restart from entry 0
        begin
          armed   <= 1'b1;
          done    <= 1'b0;
          started <= 1'b0;
          wr_ptr  <= '0;
        end
      end
      else if (cap_en)
      begin
        started <= 1'b1;
        wr_ptr  <= wr_ptr + 1'b1;
        if (wr_ptr == scope_ptr_w'(scope_depth-1)) // last entry
        begin
          armed   <= 1'b0;
          started <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

  // sample buffer, one write port and one read port
  always_ff @(posedge adc_clk)
  begin
    if (cap_en)
      buf_mem[wr_ptr] <= {adc_b_i, adc_a_i};
    if (buf_rd && !rd_wait)
      rd_data <= buf_mem[rd_idx];
  end

  ////////////////////////////////////////////////////////////
  // APB read side
  ////////////////////////////////////////////////////////////

  assign pready_o = ~buf_rd | rd_wait;

  always_comb
  begin
    prdata_o  = '0;
    pslverr_o = 1'b0;
    if (is_ctrl)
      prdata_o[1:0] = {done, armed};
    else if (is_level)
      prdata_o = {{(apb_data_w-sample_w){trig_lvl[sample_w-1]}}, trig_lvl};
    else if (is_buf)
    begin
      prdata_o = {{(apb_data_w/2-sample_w){rd_data[2*sample_w-1]}},
                  rd_data[2*sample_w-1:sample_w],
                  {(apb_data_w/2-sample_w){rd_data[sample_w-1]}},
                  rd_data[sample_w-1:0]};
      pslverr_o = access & pwrite_i;  // buffer is read only
    end
    else
      pslverr_o = access;             // hole in the map
  end

endmodule

// File: analog/dac_backend.sv
////////////////////////////////////////////////////////////
// signed levels to neg-slope offset code, one register stage
// reset value is level zero in DAC code, 0x1FFF
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module dac_backend (
  input  logic                                   adc_clk,
  input  logic                                   arst_n_i,
  input  logic signed [pitaya_pkg::sample_w-1:0] dac_lvl_a_i,
  input  logic signed [pitaya_pkg::sample_w-1:0] dac_lvl_b_i,
  output logic [pitaya_pkg::sample_w-1:0]        dac_dat_a_o,
  output logic [pitaya_pkg::sample_w-1:0]        dac_dat_b_o
);

  import pitaya_pkg::*;

  // output registers, same flip as on the ADC side
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_dat_a_o <= conv_mask; // mid scale
      dac_dat_b_o <= conv_mask;
    end
    else
    begin
      dac_dat_a_o <= dac_lvl_a_i ^ conv_mask;
      dac_dat_b_o <= dac_lvl_b_i ^ conv_mask;
    end
  end

endmodule

// File: analog/adc_frontend.sv
////////////////////////////////////////////////////////////
// raw ADC words registered once, then made two's complement
// loopback bypasses the register, level appears at once
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module adc_frontend (
  input  logic                                   adc_clk,
  input  logic                                   arst_n_i,
  input  logic [pitaya_pkg::sample_w-1:0]        adc_dat_a_i,
  input  logic [pitaya_pkg::sample_w-1:0]        adc_dat_b_i,
  input  logic                                   dig_loop_i,
  input  logic signed [pitaya_pkg::sample_w-1:0] dac_lvl_a_i,
  input  logic signed [pitaya_pkg::sample_w-1:0] dac_lvl_b_i,
  output logic signed [pitaya_pkg::sample_w-1:0] adc_a_o,
  output logic signed [pitaya_pkg::sample_w-1:0] adc_b_o
);

  import pitaya_pkg::*;

  logic [sample_w-1:0] adc_raw_a, adc_raw_b; // input registers, offset code

  // input capture, ideally packed into the IO cells
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      adc_raw_a <= '0;
      adc_raw_b <= '0;
    end
    else
    begin
      adc_raw_a <= adc_dat_a_i;
      adc_raw_b <= adc_dat_b_i;
    end
  end

  // neg-slope offset to signed, msb kept, lower 13 bits flipped
  assign adc_a_o = dig_loop_i ? dac_lvl_a_i : $signed(adc_raw_a ^ conv_mask);
  assign adc_b_o = dig_loop_i ? dac_lvl_b_i : $signed(adc_raw_b ^ conv_mask);

endmodule

// File: verilog/housekeeping.sv
////////////////////////////////////////////////////////////
// region 0 registers, zero wait states
// unknown offsets complete with pslverr and change nothing
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module housekeeping (
  input  logic                                    adc_clk,
  input  logic                                    arst_n_i,
  input  logic                                    psel_i,
  input  logic                                    penable_i,
  input  logic                                    pwrite_i,
  input  logic [pitaya_pkg::region_lsb-1:0]       paddr_i,
  input  logic [pitaya_pkg::apb_data_w-1:0]       pwdata_i,
  output logic [pitaya_pkg::apb_data_w-1:0]       prdata_o,
  output logic                                    pready_o,
  output logic                                    pslverr_o,
  output logic                                    dig_loop_o,
  output logic [7:0]                              led_o,
  output logic signed [pitaya_pkg::sample_w-1:0]  dac_lvl_a_o,
  output logic signed [pitaya_pkg::sample_w-1:0]  dac_lvl_b_o
);

  import pitaya_pkg::*;

  logic access; // access phase
  logic wr_en;
  logic known;  // offset decodes to a register

  assign access   = psel_i & penable_i;
  assign wr_en    = access & pwrite_i;
  assign pready_o = 1'b1;                // never waits

  ////////////////////////////////////////////////////////////
  // register writes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dig_loop_o  <= 1'b0;
      led_o       <= '0;
      dac_lvl_a_o <= '0;
      dac_lvl_b_o <= '0;
    end
    else if (wr_en)
    begin
      case (paddr_i)
        off_loop:  dig_loop_o  <= pwdata_i[0];
        off_led:   led_o       <= pwdata_i[7:0];
        off_dac_a: dac_lvl_a_o <= pwdata_i[sample_w-1:0]; // upper bits dropped
        off_dac_b: dac_lvl_b_o <= pwdata_i[sample_w-1:0];
        default:   ;                                      // id is read only
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read back
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    prdata_o = '0;
    known    = 1'b1;
    case (paddr_i)
      off_id:    prdata_o = hk_id_value;
      off_loop:  prdata_o[0] = dig_loop_o;
      off_led:   prdata_o[7:0] = led_o;
      off_dac_a: prdata_o = {{(apb_data_w-sample_w){dac_lvl_a_o[sample_w-1]}}, dac_lvl_a_o};
      off_dac_b: prdata_o = {{(apb_data_w-sample_w){dac_lvl_b_o[sample_w-1]}}, dac_lvl_b_o};
      default:   known = 1'b0;
    endcase
  end

  assign pslverr_o = access & ~known; // only in the access phase

endmodule

// File: verilog/apb_region_decoder.sv
////////////////////////////////////////////////////////////
// paddr[22:20] picks one of eight regions
// regions without a slave answer at once, zero data, no error
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module apb_region_decoder (
  input  logic [pitaya_pkg::apb_addr_w-1:0] paddr_i,
  input  logic                              psel_i,
  output logic                              hk_psel_o,
  output logic                              scope_psel_o,
  input  logic [pitaya_pkg::apb_data_w-1:0] hk_prdata_i,
  input  logic                              hk_pready_i,
  input  logic                              hk_pslverr_i,
  input  logic [pitaya_pkg::apb_data_w-1:0] scope_prdata_i,
  input  logic                              scope_pready_i,
  input  logic                              scope_pslverr_i,
  output logic [pitaya_pkg::apb_data_w-1:0] prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o
);

  import pitaya_pkg::*;

  logic [region_msb-region_lsb:0] region;     // region field
  logic [num_regions-1:0]         region_sel; // one-hot, only with psel

  assign region     = paddr_i[region_msb:region_lsb];
  assign region_sel = psel_i ? (num_regions'(1) << region) : '0;

  assign hk_psel_o    = region_sel[region_hk];
  assign scope_psel_o = region_sel[region_scope];

  // response mux, default is the empty slave
  always_comb
  begin
    prdata_o  = '0;
    pready_o  = 1'b1;
    pslverr_o = 1'b0;
    if (region_sel[region_hk])
    begin
      prdata_o  = hk_prdata_i;
      pready_o  = hk_pready_i;
      pslverr_o = hk_pslverr_i;
    end
    else if (region_sel[region_scope])
    begin
      prdata_o  = scope_prdata_i;
      pready_o  = scope_pready_i;  // stretched on buffer reads
      pslverr_o = scope_pslverr_i;
    end
  end

endmodule

// File: common/pitaya_pkg.sv
////////////////////////////////////////////////////////////
// widths, address map and register offsets shared by all
// blocks; offsets are relative to the start of a region
////////////////////////////////////////////////////////////

package pitaya_pkg;

  ////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////

  localparam int sample_w = 14; // ADC and DAC sample width

  // neg-slope offset code <-> two's complement, keep msb and flip the rest
  localparam logic [sample_w-1:0] conv_mask = {1'b0, {(sample_w-1){1'b1}}};

  ////////////////////////////////////////////////////////////
  // APB and region map
  ////////////////////////////////////////////////////////////

  localparam int apb_addr_w = 32;
  localparam int apb_data_w = 32;

  localparam int region_lsb  = 20; // region field is paddr[22:20]
  localparam int region_msb  = 22;
  localparam int num_regions = 8;

  localparam int region_hk    = 0;
  localparam int region_scope = 1;

  // housekeeping, region 0
  localparam logic [apb_data_w-1:0] hk_id_value = 32'h5250_544B; // "RPTK"

  localparam logic [region_lsb-1:0] off_id    = 20'h0_0000;
  localparam logic [region_lsb-1:0] off_loop  = 20'h0_0004;
  localparam logic [region_lsb-1:0] off_led   = 20'h0_0008;
  localparam logic [region_lsb-1:0] off_dac_a = 20'h0_000C;
  localparam logic [region_lsb-1:0] off_dac_b = 20'h0_0010;

  // scope, region 1
  localparam logic [region_lsb-1:0] off_ctrl     = 20'h0_0000;
  localparam logic [region_lsb-1:0] off_level    = 20'h0_0004;
  localparam logic [region_lsb-1:0] off_buf_base = 20'h1_0000; // one word per entry

  localparam int scope_depth = 256;
  localparam int scope_ptr_w = 8;

endpackage
